// File: ls_pkg.sv
// shared vector types, funct3 codes and sub-unit numbering for the load/store unit
`default_nettype none

package ls_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // vector types
    ////////////////////////////////////////////////////////////////////////////

    // byte address, no translation
    typedef logic [31:0] addr_t;

    // load or store data word
    typedef logic [31:0] data_t;

    // one enable per byte lane
    typedef logic [3:0] byte_en_t;

    // id carried from issue to writeback
    typedef logic [3:0] instr_id_t;

    // load/store funct3
    typedef logic [2:0] fn3_t;

    ////////////////////////////////////////////////////////////////////////////
    // funct3 encodings
    ////////////////////////////////////////////////////////////////////////////

    // bit 2 set means zero extend, bits 1:0 give the access size
    localparam fn3_t LS_B = 3'b000;
    localparam fn3_t LS_H = 3'b001;
    localparam fn3_t LS_W = 3'b010;
    localparam fn3_t L_BU = 3'b100;
    localparam fn3_t L_HU = 3'b101;

    ////////////////////////////////////////////////////////////////////////////
    // sub-units
    ////////////////////////////////////////////////////////////////////////////

    // scratch memory and wishbone master
    localparam int NUM_SUB_UNITS = 2;

    // bit positions in the one-hot unit select
    localparam int SCRATCH_ID = 0;
    localparam int BUS_ID = 1;

endpackage

`default_nettype wire

// File: ls_sub_if.sv
// interface between the issue side, one sub-unit and the return side
`timescale 1ns/1ps
`default_nettype none

interface ls_sub_if;
    import ls_pkg::*;

    // request, valid for one cycle only
    logic new_request;
    addr_t addr;
    logic load;
    logic store;
    byte_en_t be;
    data_t data_in;

    // unit status and load return
    logic ready;
    logic data_valid;
    // all zero while data_valid is low
    data_t data_out;

    modport issuer (output new_request, addr, load, store, be, data_in, input ready);

    modport unit (
        input new_request, addr, load, store, be, data_in,
        output ready, data_valid, data_out
    );

    modport returner (input data_valid, data_out);

endinterface

`default_nettype wire

// File: ls_fifo.sv
// synchronous circular FIFO with head shown on data_out
`timescale 1ns/1ps
`default_nettype none

module ls_fifo #(
    parameter int DATA_WIDTH = 8,
    parameter int DEPTH = 4
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic push,
    input  wire logic pop,
    input  wire logic [DATA_WIDTH-1:0] data_in,
    output logic [DATA_WIDTH-1:0] data_out,
    output logic valid,
    output logic full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    logic [DATA_WIDTH-1:0] storage [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    // requests that cannot be served are dropped
    assign do_push = push && !full;
    assign do_pop = pop && valid;

    assign valid = (count != '0);
    assign full = (count == CNT_W'(DEPTH));
    assign data_out = storage[rd_ptr];

    // pointers and fill level
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    // payload storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            storage[wr_ptr] <= data_in;
        end
    end

endmodule

`default_nettype wire

// File: ls_issue.sv
// request FIFO, alignment check, byte enables, store lanes, unit decode and issue control
`timescale 1ns/1ps
`default_nettype none

module ls_issue #(
    parameter int INPUT_DEPTH = 4,
    parameter logic [3:0] SCRATCH_REGION = 4'h0
) (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic req_valid,
    input  wire logic req_load,
    input  wire logic req_store,
    input  wire ls_pkg::fn3_t req_fn3,
    input  wire ls_pkg::addr_t req_addr,
    input  wire ls_pkg::data_t req_data,
    input  wire ls_pkg::instr_id_t req_id,
    output logic req_ready,
    input  wire logic load_done,
    ls_sub_if.issuer scratch,
    ls_sub_if.issuer bus,
    output logic load_issued,
    output ls_pkg::fn3_t load_fn3,
    output logic [1:0] load_byte,
    output ls_pkg::instr_id_t load_id,
    output logic misaligned_valid,
    output ls_pkg::instr_id_t misaligned_id
);
    import ls_pkg::*;

    localparam int REQ_W = 2 + $bits(fn3_t) + $bits(addr_t) + $bits(data_t) + $bits(instr_id_t);

    logic [REQ_W-1:0] fifo_out;
    logic head_valid;
    logic fifo_full;
    logic fifo_pop;
    logic head_load;
    logic head_store;
    fn3_t head_fn3;
    addr_t head_addr;
    data_t head_data;
    instr_id_t head_id;

    logic misaligned;
    byte_en_t be;
    data_t store_lanes;
    logic [NUM_SUB_UNITS-1:0] unit_sel;
    logic [NUM_SUB_UNITS-1:0] unit_ready;
    logic [NUM_SUB_UNITS-1:0] last_unit;
    logic [1:0] load_count;
    logic unit_ok;
    logic issue;

    ////////////////////////////////////////////////////////////////////////////
    // input FIFO
    ////////////////////////////////////////////////////////////////////////////

    assign req_ready = !fifo_full;

    ls_fifo #(
        .DATA_WIDTH(REQ_W),
        .DEPTH(INPUT_DEPTH)
    ) request_fifo (
        .clk(clk),
        .rst(rst),
        .push(req_valid && req_ready),
        .pop(fifo_pop),
        .data_in({req_load, req_store, req_fn3, req_addr, req_data, req_id}),
        .data_out(fifo_out),
        .valid(head_valid),
        .full(fifo_full)
    );

    assign {head_load, head_store, head_fn3, head_addr, head_data, head_id} = fifo_out;

    ////////////////////////////////////////////////////////////////////////////
    // alignment, byte enables, store data
    ////////////////////////////////////////////////////////////////////////////

    // size lives in the low funct3 bits
    always_comb begin
        case (head_fn3[1:0])
            LS_H[1:0]: misaligned = head_addr[0];
            LS_W[1:0]: misaligned = |head_addr[1:0];
            default: misaligned = 1'b0;
        endcase
    end

    // enables only for stores, loads read the whole word
    always_comb begin
        for (int i = 0; i < 4; i++) begin
            case (head_fn3[1:0])
                LS_B[1:0]: be[i] = head_store && (head_addr[1:0] == i[1:0]);
                LS_H[1:0]: be[i] = head_store && (head_addr[1] == i[1]);
                default: be[i] = head_store;
            endcase
        end
    end

    // replicate into every lane, the enables pick the right one
    always_comb begin
        case (head_fn3[1:0])
            LS_B[1:0]: store_lanes = {4{head_data[7:0]}};
            LS_H[1:0]: store_lanes = {2{head_data[15:0]}};
            default: store_lanes = head_data;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // unit decode and issue
    ////////////////////////////////////////////////////////////////////////////

    // one region for scratch, everything else on the bus
    assign unit_sel[SCRATCH_ID] = (head_addr[31:28] == SCRATCH_REGION);
    assign unit_sel[BUS_ID] = (head_addr[31:28] != SCRATCH_REGION);
    assign unit_ready[SCRATCH_ID] = scratch.ready;
    assign unit_ready[BUS_ID] = bus.ready;

    // switching units only once all loads have drained keeps results in order
    assign unit_ok = (unit_sel == last_unit) || (load_count == 2'd0);

    assign issue = head_valid && !misaligned && |(unit_sel & unit_ready)
                   && (load_count < 2'd2) && unit_ok;

    // bad alignment is dropped straight from the head
    assign fifo_pop = issue || (head_valid && misaligned);
    assign misaligned_valid = head_valid && misaligned;
    assign misaligned_id = head_id;

    // loads between issue and writeback acceptance
    always_ff @(posedge clk) begin
        if (rst) begin
            load_count <= 2'd0;
            last_unit <= '0;
        end else begin
            if (load_issued && !load_done) begin
                load_count <= load_count + 2'd1;
            end else if (load_done && !load_issued) begin
                load_count <= load_count - 2'd1;
            end
            if (load_issued) begin
                last_unit <= unit_sel;
            end
        end
    end

    // same request to both units, only the selected one sees new_request
    assign scratch.new_request = issue && unit_sel[SCRATCH_ID];
    assign scratch.addr = head_addr;
    assign scratch.load = head_load;
    assign scratch.store = head_store;
    assign scratch.be = be;
    assign scratch.data_in = store_lanes;

    assign bus.new_request = issue && unit_sel[BUS_ID];
    assign bus.addr = head_addr;
    assign bus.load = head_load;
    assign bus.store = head_store;
    assign bus.be = be;
    assign bus.data_in = store_lanes;

    // attributes for the return side
    assign load_issued = issue && head_load;
    assign load_fn3 = head_fn3;
    assign load_byte = head_addr[1:0];
    assign load_id = head_id;

endmodule

`default_nettype wire

// File: ls_scratch_mem.sv
// scratch data memory sub-unit, byte-enabled writes and one-cycle reads
`timescale 1ns/1ps
`default_nettype none

module ls_scratch_mem #(
    parameter int SCRATCH_WORDS = 256
) (
    input  wire logic clk,
    input  wire logic rst,
    ls_sub_if.unit ls
);
    import ls_pkg::*;

    localparam int IDX_W = $clog2(SCRATCH_WORDS);

    data_t mem [SCRATCH_WORDS];
    logic [IDX_W-1:0] index;
    data_t read_word;
    logic read_valid;

    // word index from the low address bits
    assign index = ls.addr[IDX_W+1:2];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int w = 0; w < SCRATCH_WORDS; w++) begin
                mem[w] <= '0;
            end
            read_valid <= 1'b0;
        end else begin
            read_valid <= ls.new_request && ls.load;
            if (ls.new_request && ls.store) begin
                for (int b = 0; b < 4; b++) begin
                    if (ls.be[b]) begin
                        mem[index][b*8 +: 8] <= ls.data_in[b*8 +: 8];
                    end
                end
            end
            if (ls.new_request && ls.load) begin
                read_word <= mem[index];
            end
        end
    end

    // never busy
    assign ls.ready = 1'b1;
    assign ls.data_valid = read_valid;
    assign ls.data_out = read_valid ? read_word : '0;

endmodule

`default_nettype wire

// File: ls_wb_master.sv
// wishbone classic master sub-unit for bus-mapped addresses
`timescale 1ns/1ps
`default_nettype none

module ls_wb_master (
    input  wire logic clk,
    input  wire logic rst,
    ls_sub_if.unit ls,
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output ls_pkg::addr_t wb_adr,
    output ls_pkg::byte_en_t wb_sel,
    output ls_pkg::data_t wb_dat_o,
    input  wire ls_pkg::data_t wb_dat_i,
    input  wire logic wb_ack
);
    import ls_pkg::*;

    typedef enum logic [1:0] {
        IDLE,
        BUS_CYCLE,
        RESPOND
    } wb_state_t;

    wb_state_t state;
    logic is_load;
    data_t read_data;

    // one classic cycle per request
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE: if (ls.new_request) state <= BUS_CYCLE;
                BUS_CYCLE: if (wb_ack) state <= RESPOND;
                default: state <= IDLE;
            endcase
        end
    end

    // request held stable for the whole cycle
    always_ff @(posedge clk) begin
        if (ls.new_request) begin
            is_load <= ls.load;
            wb_we <= ls.store;
            wb_adr <= {ls.addr[31:2], 2'b00};
            // full word read, lanes picked on return
            wb_sel <= ls.load ? 4'hf : ls.be;
            wb_dat_o <= ls.data_in;
        end
        if (state == BUS_CYCLE && wb_ack) begin
            read_data <= wb_dat_i;
        end
    end

    assign wb_cyc = (state == BUS_CYCLE);
    assign wb_stb = (state == BUS_CYCLE);

    // busy until the response cycle is over
    assign ls.ready = (state == IDLE);
    assign ls.data_valid = (state == RESPOND) && is_load;
    assign ls.data_out = ls.data_valid ? read_data : '0;

endmodule

`default_nettype wire

// File: ls_load_return.sv
// load attributes, lane select, sign/zero extension and two-entry writeback buffer
`timescale 1ns/1ps
`default_nettype none

module ls_load_return (
    input  wire logic clk,
    input  wire logic rst,
    input  wire logic load_issued,
    input  wire ls_pkg::fn3_t load_fn3,
    input  wire logic [1:0] load_byte,
    input  wire ls_pkg::instr_id_t load_id,
    ls_sub_if.returner scratch,
    ls_sub_if.returner bus,
    output logic wb_valid,
    output ls_pkg::data_t wb_data,
    output ls_pkg::instr_id_t wb_id,
    input  wire logic wb_accepted,
    output logic load_done
);
    import ls_pkg::*;

    localparam int ATTR_W = $bits(fn3_t) + 2 + $bits(instr_id_t);

    logic [ATTR_W-1:0] attr_out;
    logic attr_valid;
    fn3_t attr_fn3;
    logic [1:0] attr_byte;
    instr_id_t attr_id;

    logic data_valid;
    data_t unit_data;
    logic [15:0] half_sel;
    logic [7:0] byte_sel;
    data_t result;

    // second writeback entry
    logic tail_valid;
    data_t tail_data;
    instr_id_t tail_id;

    ////////////////////////////////////////////////////////////////////////////
    // attributes, one per load in flight
    ////////////////////////////////////////////////////////////////////////////

    ls_fifo #(
        .DATA_WIDTH(ATTR_W),
        .DEPTH(2)
    ) attr_fifo (
        .clk(clk),
        .rst(rst),
        .push(load_issued),
        .pop(data_valid && attr_valid),
        .data_in({load_fn3, load_byte, load_id}),
        .data_out(attr_out),
        .valid(attr_valid),
        .full()
    );

    assign {attr_fn3, attr_byte, attr_id} = attr_out;

    ////////////////////////////////////////////////////////////////////////////
    // data select and extension
    ////////////////////////////////////////////////////////////////////////////

    // idle units return zero
    assign data_valid = scratch.data_valid || bus.data_valid;
    assign unit_data = scratch.data_out | bus.data_out;

    // halfword first, then byte within it
    assign half_sel = attr_byte[1] ? unit_data[31:16] : unit_data[15:0];
    assign byte_sel = attr_byte[0] ? half_sel[15:8] : half_sel[7:0];

    always_comb begin
        case (attr_fn3)
            LS_B: result = {{24{byte_sel[7]}}, byte_sel};
            LS_H: result = {{16{half_sel[15]}}, half_sel};
            L_BU: result = {24'b0, byte_sel};
            L_HU: result = {16'b0, half_sel};
            default: result = unit_data;
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // writeback buffer, head drives the port
    ////////////////////////////////////////////////////////////////////////////

    assign load_done = wb_valid && wb_accepted;

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_valid <= 1'b0;
            tail_valid <= 1'b0;
        end else if (load_done) begin
            // tail moves up, a new result lands behind it
            wb_valid <= tail_valid || data_valid;
            wb_data <= tail_valid ? tail_data : result;
            wb_id <= tail_valid ? tail_id : attr_id;
            tail_valid <= tail_valid && data_valid;
            tail_data <= result;
            tail_id <= attr_id;
        end else if (data_valid) begin
            if (!wb_valid) begin
                wb_valid <= 1'b1;
                wb_data <= result;
                wb_id <= attr_id;
            end else begin
                tail_valid <= 1'b1;
                tail_data <= result;
                tail_id <= attr_id;
            end
        end
    end

endmodule

`default_nettype wire

// File: load_store_unit.sv
// load/store unit top level, issue side, scratch memory, wishbone master, return side
`timescale 1ns/1ps
`default_nettype none

module load_store_unit #(
    parameter int INPUT_DEPTH = 4,
    parameter int SCRATCH_WORDS = 256,
    parameter logic [3:0] SCRATCH_REGION = 4'h0
) (
    input  wire logic clk,
    input  wire logic rst,
    // issue stage
    input  wire logic req_valid,
    input  wire logic req_load,
    input  wire logic req_store,
    input  wire ls_pkg::fn3_t req_fn3,
    input  wire ls_pkg::addr_t req_addr,
    input  wire ls_pkg::data_t req_data,
    input  wire ls_pkg::instr_id_t req_id,
    output logic req_ready,
    // writeback
    output logic wb_valid,
    output ls_pkg::data_t wb_data,
    output ls_pkg::instr_id_t wb_id,
    input  wire logic wb_accepted,
    // exceptions
    output logic misaligned_valid,
    output ls_pkg::instr_id_t misaligned_id,
    // wishbone
    output logic wb_cyc,
    output logic wb_stb,
    output logic wb_we,
    output ls_pkg::addr_t wb_adr,
    output ls_pkg::byte_en_t wb_sel,
    output ls_pkg::data_t wb_dat_o,
    input  wire ls_pkg::data_t wb_dat_i,
    input  wire logic wb_ack
);
    import ls_pkg::*;

    logic load_done;
    logic load_issued;
    fn3_t load_fn3;
    logic [1:0] load_byte;
    instr_id_t load_id;

    ls_sub_if scratch_if ();
    ls_sub_if bus_if ();

    ls_issue #(
        .INPUT_DEPTH(INPUT_DEPTH),
        .SCRATCH_REGION(SCRATCH_REGION)
    ) issue (
        .clk(clk),
        .rst(rst),
        .req_valid(req_valid),
        .req_load(req_load),
        .req_store(req_store),
        .req_fn3(req_fn3),
        .req_addr(req_addr),
        .req_data(req_data),
        .req_id(req_id),
        .req_ready(req_ready),
        .load_done(load_done),
        .scratch(scratch_if.issuer),
        .bus(bus_if.issuer),
        .load_issued(load_issued),
        .load_fn3(load_fn3),
        .load_byte(load_byte),
        .load_id(load_id),
        .misaligned_valid(misaligned_valid),
        .misaligned_id(misaligned_id)
    );

    ls_scratch_mem #(
        .SCRATCH_WORDS(SCRATCH_WORDS)
    ) scratch_mem (
        .clk(clk),
        .rst(rst),
        .ls(scratch_if.unit)
    );

    ls_wb_master bus_master (
        .clk(clk),
        .rst(rst),
        .ls(bus_if.unit),
        .wb_cyc(wb_cyc),
        .wb_stb(wb_stb),
        .wb_we(wb_we),
        .wb_adr(wb_adr),
        .wb_sel(wb_sel),
        .wb_dat_o(wb_dat_o),
        .wb_dat_i(wb_dat_i),
        .wb_ack(wb_ack)
    );

    ls_load_return load_return (
        .clk(clk),
        .rst(rst),
        .load_issued(load_issued),
        .load_fn3(load_fn3),
        .load_byte(load_byte),
        .load_id(load_id),
        .scratch(scratch_if.returner),
        .bus(bus_if.returner),
        .wb_valid(wb_valid),
        .wb_data(wb_data),
        .wb_id(wb_id),
        .wb_accepted(wb_accepted),
        .load_done(load_done)
    );

endmodule

`default_nettype wire

// File: ls_tb.sv
// testbench for the load/store unit, wishbone slave model, pattern stimulus and checks
`timescale 1ns/1ps
`default_nettype none

module ls_tb;
    import ls_pkg::*;

    localparam int MAX_PATTERNS = 64;
    localparam int FIELDS = 7;
    localparam int FIRST_STALL = 32;
    localparam logic [3:0] SCRATCH_REGION = 4'h0;

    logic clk;
    logic rst;
    logic req_valid;
    logic req_load;
    logic req_store;
    fn3_t req_fn3;
    addr_t req_addr;
    data_t req_data;
    instr_id_t req_id;
    logic req_ready;
    logic wb_valid;
    data_t wb_data;
    instr_id_t wb_id;
    logic wb_accepted;
    logic misaligned_valid;
    instr_id_t misaligned_id;
    logic wb_cyc;
    logic wb_stb;
    logic wb_we;
    addr_t wb_adr;
    byte_en_t wb_sel;
    data_t wb_dat_o;
    data_t wb_dat_i;
    logic wb_ack;

    // seven pattern words per request
    logic [31:0] pat_mem [0:MAX_PATTERNS*FIELDS-1];
    int num_patterns = 0;
    logic patterns_loaded = 1'b0;
    int value_errors = 0;
    int other_errors = 0;

    // expectations in request order
    logic [35:0] wb_expect [$];
    logic [3:0] exc_expect [$];
    logic [68:0] bus_expect [$];

    // slave model state as tagged words over a small index
    logic [31:0] bus_words [0:63];
    logic [31:0] bus_tags [0:63];
    logic bus_written [0:63];
    logic bus_busy;
    int wait_left;
    logic [68:0] cur_bus;

    int stall_left;
    logic hold_pending;
    data_t held_data;
    instr_id_t held_id;
    logic saw_ready_low = 1'b0;
    logic saw_ready_recover = 1'b0;

    load_store_unit #(
        .INPUT_DEPTH(4),
        .SCRATCH_WORDS(256),
        .SCRATCH_REGION(SCRATCH_REGION)
    ) dut (
        .clk(clk), .rst(rst),
        .req_valid(req_valid), .req_load(req_load), .req_store(req_store),
        .req_fn3(req_fn3), .req_addr(req_addr), .req_data(req_data),
        .req_id(req_id), .req_ready(req_ready),
        .wb_valid(wb_valid), .wb_data(wb_data), .wb_id(wb_id),
        .wb_accepted(wb_accepted),
        .misaligned_valid(misaligned_valid), .misaligned_id(misaligned_id),
        .wb_cyc(wb_cyc), .wb_stb(wb_stb), .wb_we(wb_we), .wb_adr(wb_adr),
        .wb_sel(wb_sel), .wb_dat_o(wb_dat_o), .wb_dat_i(wb_dat_i), .wb_ack(wb_ack)
    );

    // 40 ns clock
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    ////////////////////////////////////////////////////////////////////////////
    // reporting and reference helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] exp);
        $display("** Error at %0t ns: %s = %h, expected %h", $time, name, got, exp);
        value_errors++;
    endtask

    task automatic report_failure(input string what);
        $display("failure at %0t ns: %s", $time, what);
        other_errors++;
    endtask

    // loads read the whole word and stores enable the addressed lanes
    function automatic byte_en_t expected_sel(input logic is_load, input fn3_t fn3,
                                              input addr_t addr);
        if (is_load) return 4'hf;
        if (fn3[1:0] == LS_B[1:0]) return 4'b0001 << addr[1:0];
        if (fn3[1:0] == LS_H[1:0]) return addr[1] ? 4'b1100 : 4'b0011;
        return 4'hf;
    endfunction

    function automatic data_t replicate_lanes(input fn3_t fn3, input data_t data);
        if (fn3[1:0] == LS_B[1:0]) return {4{data[7:0]}};
        if (fn3[1:0] == LS_H[1:0]) return {2{data[15:0]}};
        return data;
    endfunction

    // unwritten words come from a fill over the full address
    function automatic data_t bus_read(input addr_t adr);
        logic [5:0] idx;
        idx = adr[7:2];
        if (bus_written[idx] && bus_tags[idx] == adr) return bus_words[idx];
        return adr ^ 32'h5a5a5a5a;
    endfunction

    task automatic bus_write(input addr_t adr, input byte_en_t sel, input data_t dat);
        data_t word;
        word = bus_read(adr);
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) word[b*8 +: 8] = dat[b*8 +: 8];
        end
        bus_words[adr[7:2]] = word;
        bus_tags[adr[7:2]] = adr;
        bus_written[adr[7:2]] = 1'b1;
    endtask

    task automatic send_request(input logic is_load, input fn3_t fn3, input addr_t addr,
                                input data_t data, input instr_id_t id);
        logic taken;
        taken = 1'b0;
        @(negedge clk);
        req_valid = 1'b1;
        req_load = is_load;
        req_store = !is_load;
        req_fn3 = fn3;
        req_addr = addr;
        req_data = data;
        req_id = id;
        // transfer on the edge that sees ready high
        while (!taken) begin
            @(posedge clk);
            taken = req_ready;
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // wishbone slave model with 0 to 3 wait cycles
    ////////////////////////////////////////////////////////////////////////////

    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            wb_ack = 1'b0;
            bus_busy = 1'b0;
            wait_left = 0;
            for (int w = 0; w < 64; w++) bus_written[w] = 1'b0;
        end else if (wb_cyc && wb_stb && !wb_ack) begin
            if (!bus_busy) begin
                bus_busy = 1'b1;
                wait_left = $urandom % 4;
                if (bus_expect.size() == 0) begin
                    report_failure("bus cycle started with no bus request pending");
                    cur_bus = {wb_we, wb_adr, wb_sel, wb_dat_o};
                end else begin
                    cur_bus = bus_expect.pop_front();
                end
            end
            // held stable through every wait cycle
            if (wb_we !== cur_bus[68]) report_mismatch("wb_we", wb_we, cur_bus[68]);
            if (wb_adr !== cur_bus[67:36]) report_mismatch("wb_adr", wb_adr, cur_bus[67:36]);
            if (wb_sel !== cur_bus[35:32]) report_mismatch("wb_sel", wb_sel, cur_bus[35:32]);
            if (cur_bus[68] && wb_dat_o !== cur_bus[31:0]) begin
                report_mismatch("wb_dat_o", wb_dat_o, cur_bus[31:0]);
            end
            if (wait_left == 0) begin
                if (wb_we) bus_write(wb_adr, wb_sel, wb_dat_o);
                else wb_dat_i = bus_read(wb_adr);
                wb_ack = 1'b1;
                bus_busy = 1'b0;
            end else begin
                wait_left = wait_left - 1;
            end
        end else begin
            wb_ack = 1'b0;
        end
    end

    // writeback stalls with a long one first to fill the input FIFO
    always @(negedge clk) begin
        if (rst !== 1'b0) begin
            wb_accepted = 1'b0;
            stall_left = FIRST_STALL;
        end else if (stall_left > 0) begin
            wb_accepted = 1'b0;
            stall_left = stall_left - 1;
        end else begin
            wb_accepted = 1'b1;
            if ($urandom % 4 == 0) stall_left = $urandom % 16;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output monitors on pre-edge values
    ////////////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (!rst) begin
            if (wb_cyc !== wb_stb) report_mismatch("wb_stb", wb_stb, wb_cyc);
            if (!req_ready) saw_ready_low = 1'b1;
            if (saw_ready_low && req_ready) saw_ready_recover = 1'b1;
            if (misaligned_valid) begin
                if (exc_expect.size() == 0) begin
                    report_failure("misaligned_valid raised with no misaligned request");
                end else if (misaligned_id !== exc_expect[0]) begin
                    report_mismatch("misaligned_id", misaligned_id, exc_expect.pop_front());
                end else begin
                    void'(exc_expect.pop_front());
                end
            end
            // unaccepted entry keeps its value
            if (hold_pending) begin
                if (!wb_valid) begin
                    report_failure("wb_valid dropped before the entry was accepted");
                end else begin
                    if (wb_data !== held_data) report_mismatch("wb_data", wb_data, held_data);
                    if (wb_id !== held_id) report_mismatch("wb_id", wb_id, held_id);
                end
            end
            if (wb_valid && wb_accepted) begin
                if (wb_expect.size() == 0) begin
                    report_failure("writeback accepted with no load pending");
                end else begin
                    if (wb_data !== wb_expect[0][31:0]) begin
                        report_mismatch("wb_data", wb_data, wb_expect[0][31:0]);
                    end
                    if (wb_id !== wb_expect[0][35:32]) begin
                        report_mismatch("wb_id", wb_id, wb_expect[0][35:32]);
                    end
                    void'(wb_expect.pop_front());
                end
            end
            hold_pending = wb_valid && !wb_accepted;
            held_data = wb_data;
            held_id = wb_id;
        end
    end

    // 200 cycles per pattern after reset
    initial begin
        wait (patterns_loaded);
        repeat (16 + num_patterns * 200) @(posedge clk);
        $display("timeout: the run did not drain all requests in time");
        $display("SOME TESTS FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        logic is_load;
        fn3_t fn3;
        addr_t addr;
        data_t data;
        instr_id_t id;
        int base;
        void'($urandom(32'h725e1de7));
        rst = 1'b1;
        req_valid = 1'b0;
        req_load = 1'b0;
        req_store = 1'b0;
        req_fn3 = '0;
        req_addr = '0;
        req_data = '0;
        req_id = '0;
        wb_accepted = 1'b0;
        wb_dat_i = '0;
        wb_ack = 1'b0;
        hold_pending = 1'b0;
        for (int i = 0; i < MAX_PATTERNS * FIELDS; i++) pat_mem[i] = '0;
        $readmemh("ls_patterns.txt", pat_mem);
        // a zero kind ends the list
        while (num_patterns < MAX_PATTERNS && pat_mem[num_patterns * FIELDS] != 0) begin
            num_patterns++;
        end
        patterns_loaded = 1'b1;
        if (num_patterns == 0) report_failure("no patterns read from ls_patterns.txt");

        repeat (16) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        @(posedge clk);
        if (wb_valid !== 1'b0) report_mismatch("wb_valid", wb_valid, 0);
        if (misaligned_valid !== 1'b0) report_mismatch("misaligned_valid", misaligned_valid, 0);
        if (wb_cyc !== 1'b0) report_mismatch("wb_cyc", wb_cyc, 0);
        if (wb_stb !== 1'b0) report_mismatch("wb_stb", wb_stb, 0);
        if (req_ready !== 1'b1) report_mismatch("req_ready", req_ready, 1);

        for (int p = 0; p < num_patterns; p++) begin
            base = p * FIELDS;
            is_load = (pat_mem[base] == 1);
            fn3 = pat_mem[base + 1][2:0];
            addr = pat_mem[base + 2];
            data = pat_mem[base + 3];
            id = pat_mem[base + 4][3:0];
            if (pat_mem[base + 6][0]) begin
                exc_expect.push_back(id);
            end else begin
                if (is_load) wb_expect.push_back({id, pat_mem[base + 5]});
                if (addr[31:28] != SCRATCH_REGION) begin
                    bus_expect.push_back({!is_load, addr[31:2], 2'b00,
                                          expected_sel(is_load, fn3, addr),
                                          replicate_lanes(fn3, data)});
                end
            end
            send_request(is_load, fn3, addr, data, id);
        end
        @(negedge clk);
        req_valid = 1'b0;

        // drain and then watch a while for stray responses
        while (wb_expect.size() != 0 || exc_expect.size() != 0 || bus_expect.size() != 0) begin
            @(posedge clk);
        end
        repeat (20) @(posedge clk);
        if (!saw_ready_low) report_failure("req_ready never dropped under back-pressure");
        if (!saw_ready_recover) report_failure("req_ready never recovered after dropping");

        $display("%0d patterns, %0d value errors, %0d other errors",
                 num_patterns, value_errors, other_errors);
        if (value_errors + other_errors == 0) begin
            $display("ALL TESTS PASSED");
        end else begin
            $display("SOME TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: ls_patterns.txt
// kind (1 load, 2 store) fn3 address store_data id expected_load misaligned
// fn3: 0 byte, 1 half, 2 word, 4 byte unsigned, 5 half unsigned
2 2 00000010 11223344 1 00000000 0
2 1 00000010 ffffaabb 2 00000000 0
2 0 00000013 000000cc 3 00000000 0
2 1 00000016 00005566 4 00000000 0
2 0 00000015 00000080 5 00000000 0
1 2 00000010 00000000 6 cc22aabb 0
1 2 00000014 00000000 7 55668000 0
1 0 00000011 00000000 8 ffffffaa 0
1 0 00000012 00000000 9 00000022 0
1 0 00000013 00000000 a ffffffcc 0
1 4 00000010 00000000 b 000000bb 0
1 1 00000012 00000000 c ffffcc22 0
1 5 00000012 00000000 d 0000cc22 0
1 5 00000014 00000000 e 00008000 0
1 1 00000010 00000000 f ffffaabb 0
1 1 00000011 00000000 0 00000000 1
1 2 00000012 00000000 1 00000000 1
2 2 20000006 12345678 2 00000000 1
2 2 20000000 deadbeef 3 00000000 0
2 0 20000002 00000011 4 00000000 0
2 1 20000004 0000cafe 5 00000000 0
1 2 20000000 00000000 6 de11beef 0
1 5 20000004 00000000 7 0000cafe 0
1 4 20000043 00000000 8 0000007a 0
1 2 00000010 00000000 9 cc22aabb 0
1 2 20000000 00000000 a de11beef 0
1 4 00000011 00000000 b 000000aa 0
1 1 20000002 00000000 c ffffde11 0
1 2 20000004 00000000 d 7a5acafe 0
1 2 00000014 00000000 e 55668000 0

// File: tb.f
ls_pkg.sv
ls_sub_if.sv
ls_fifo.sv
ls_issue.sv
ls_scratch_mem.sv
ls_wb_master.sv
ls_load_return.sv
load_store_unit.sv
ls_tb.sv

// File: Bender.yml
package:
  name: load_store_unit

sources:
  - files:
      - ls_pkg.sv
      - ls_sub_if.sv
      - ls_fifo.sv
      - ls_issue.sv
      - ls_scratch_mem.sv
      - ls_wb_master.sv
      - ls_load_return.sv
      - load_store_unit.sv
  - target: test
    files:
      - ls_tb.sv
